//--- logic/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Cache geometry
`define NUM_SETS        16
`define WORDS_PER_LINE  4

// Bus and field widths
`define ADDR_W          32
`define DATA_W          32
`define SET_W           4
`define WORD_W          2

// Tag takes what is left above set, word and byte offsets
`define TAG_W           (`ADDR_W - `SET_W - `WORD_W - 2)

`endif

//--- logic/cachePkg.sv
`include "cache_params.svh"

package cachePkg;

  // Byte address and data word
  typedef logic [`ADDR_W-1:0]   addrT;
  typedef logic [`DATA_W-1:0]   wordT;

  // Address fields
  typedef logic [`TAG_W-1:0]    tagT;
  typedef logic [`SET_W-1:0]    setT;
  typedef logic [`WORD_W-1:0]   wordOffT;

  // One bit per byte lane
  typedef logic [`DATA_W/8-1:0] byteMaskT;

  // Controller FSM
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILL,
    FLUSHSCAN,
    FLUSHWB
  } ctrlStateT;

endpackage

//--- logic/wayStatusIf.sv
`timescale 1ns/1ps

interface wayStatusIf;

  // Lookup result for both ways of the sampled set
  logic          way0Valid;
  logic          way1Valid;
  logic          way0Dirty;
  logic          way1Dirty;
  cachePkg::tagT way0Tag;
  cachePkg::tagT way1Tag;
  logic          lruWay;

  // Set to present next cycle
  cachePkg::setT lookupSet;

  // Line update and LRU touch, both on the presented set
  logic          updEn;
  logic          updWay;
  cachePkg::tagT updTag;
  logic          updValid;
  logic          updDirty;
  logic          touchEn;
  logic          touchWay;

  modport ctrl (
    input  way0Valid, way1Valid, way0Dirty, way1Dirty, way0Tag, way1Tag, lruWay,
    output lookupSet, updEn, updWay, updTag, updValid, updDirty, touchEn, touchWay
  );

  modport store (
    output way0Valid, way1Valid, way0Dirty, way1Dirty, way0Tag, way1Tag, lruWay,
    input  lookupSet, updEn, updWay, updTag, updValid, updDirty, touchEn, touchWay
  );

endinterface

//--- logic/tagStore.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module tagStore (
  input  logic       clk,
  input  logic       reset,
  wayStatusIf.store  status
);

  cachePkg::tagT tagMem [`NUM_SETS][2];
  logic [1:0]    validBits [`NUM_SETS];
  logic [1:0]    dirtyBits [`NUM_SETS];
  // Least recently used way per set
  logic [`NUM_SETS-1:0] lruBits;
  cachePkg::setT setQ;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      setQ      <= '0;
      validBits <= '{default: '0};
      dirtyBits <= '{default: '0};
      lruBits   <= '0;
    end else begin
      setQ <= status.lookupSet;
      if (status.updEn) begin
        validBits[setQ][status.updWay] <= status.updValid;
        dirtyBits[setQ][status.updWay] <= status.updDirty;
      end
      // Touched way becomes most recent
      if (status.touchEn) begin
        lruBits[setQ] <= ~status.touchWay;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (status.updEn) begin
      tagMem[setQ][status.updWay] <= status.updTag;
    end
  end

  // Read from the registered set, so an update shows on the next cycle
  assign status.way0Valid = validBits[setQ][0];
  assign status.way1Valid = validBits[setQ][1];
  assign status.way0Dirty = dirtyBits[setQ][0];
  assign status.way1Dirty = dirtyBits[setQ][1];
  assign status.way0Tag   = tagMem[setQ][0];
  assign status.way1Tag   = tagMem[setQ][1];
  assign status.lruWay    = lruBits[setQ];

endmodule

//--- logic/dataStore.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module dataStore (
  input  logic               clk,
  input  cachePkg::setT      set,
  input  logic               way,
  input  cachePkg::wordOffT  wordOff,
  input  logic               we,
  input  cachePkg::byteMaskT byteMask,
  input  cachePkg::wordT     wData,
  output cachePkg::wordT     rData
);

  cachePkg::wordT    mem [2][`NUM_SETS][`WORDS_PER_LINE];
  cachePkg::setT     setQ;
  cachePkg::wordOffT offQ;

  always_ff @(posedge clk) begin
    setQ <= set;
    offQ <= wordOff;
    // Byte lane writes
    if (we) begin
      for (int b = 0; b < `DATA_W/8; b++) begin
        if (byteMask[b]) begin
          mem[way][set][wordOff][b*8 +: 8] <= wData[b*8 +: 8];
        end
      end
    end
  end

  // Row address registered, word lands one cycle after the address.
  // Way chosen late, once the hit is known
  assign rData = mem[way][setQ][offQ];

endmodule

//--- logic/cacheController.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cacheController (
  input  logic               clk,
  input  logic               reset,
  input  logic               cpuValid,
  output logic               cpuReady,
  input  logic               cpuWrite,
  input  cachePkg::addrT     cpuAddr,
  input  cachePkg::wordT     cpuWData,
  input  cachePkg::byteMaskT cpuByteMask,
  output logic               cpuRespValid,
  input  logic               flushValid,
  output logic               flushReady,
  output logic               flushDone,
  output logic               memValid,
  input  logic               memReady,
  output logic               memWrite,
  output cachePkg::addrT     memAddr,
  output cachePkg::wordT     memWData,
  input  cachePkg::wordT     memRData,
  wayStatusIf.ctrl           status,
  output cachePkg::setT      dataSet,
  output logic               dataWay,
  output cachePkg::wordOffT  dataWordOff,
  output logic               dataWe,
  output cachePkg::byteMaskT dataByteMask,
  output cachePkg::wordT     dataWData,
  input  cachePkg::wordT     dataRData
);

  cachePkg::ctrlStateT state, nextState;

  // Request register
  cachePkg::addrT     reqAddr;
  logic               reqWrite;
  cachePkg::wordT     reqWData;
  cachePkg::byteMaskT reqMask;

  cachePkg::wordOffT beat;
  cachePkg::setT     flushSet;
  logic              flushWay;
  logic [`SET_W:0]   flushNext;
  logic              victimWay;
  cachePkg::tagT     victimTag;

  cachePkg::setT     cpuSet, reqSet;
  cachePkg::wordOffT cpuOff, reqOff, refillOff;
  cachePkg::tagT     reqTag, missTag, scanTag;
  logic cpuFire, flushFire, memFire, lastBeat;
  logic hit0, hit1, hit, hitWay;
  logic missWay, missDirty, scanDirty, flushLast;

  assign cpuSet = cpuAddr[`WORD_W+2 +: `SET_W];
  assign cpuOff = cpuAddr[2 +: `WORD_W];
  assign reqSet = reqAddr[`WORD_W+2 +: `SET_W];
  assign reqOff = reqAddr[2 +: `WORD_W];
  assign reqTag = reqAddr[`ADDR_W-1 -: `TAG_W];

  assign cpuFire   = cpuValid & cpuReady;
  assign flushFire = flushValid & flushReady;
  assign memFire   = memValid & memReady;
  assign lastBeat  = memFire & (beat == '1);

  // Hit per way
  assign hit0   = status.way0Valid & (status.way0Tag == reqTag);
  assign hit1   = status.way1Valid & (status.way1Tag == reqTag);
  assign hit    = hit0 | hit1;
  assign hitWay = hit1;

  // Victim: an empty way first, else the LRU way
  assign missWay   = ~status.way0Valid ? 1'b0 :
                     ~status.way1Valid ? 1'b1 : status.lruWay;
  assign missTag   = missWay ? status.way1Tag : status.way0Tag;
  assign missDirty = missWay ? (status.way1Valid & status.way1Dirty)
                             : (status.way0Valid & status.way0Dirty);

  // Line under the flush scan
  assign scanTag   = flushWay ? status.way1Tag : status.way0Tag;
  assign scanDirty = flushWay ? (status.way1Valid & status.way1Dirty)
                              : (status.way0Valid & status.way0Dirty);
  assign flushLast = (flushSet == '1) & flushWay;
  assign flushNext = {flushSet, flushWay} + 1'b1;

  // Refill wraps so the requested word lands last
  assign refillOff = reqOff + beat + 2'd1;

  always_comb begin
    nextState = state;
    case (state)
      cachePkg::IDLE: begin
        if (flushFire) nextState = cachePkg::FLUSHSCAN;
        else if (cpuFire) nextState = cachePkg::LOOKUP;
      end
      cachePkg::LOOKUP: begin
        if (hit) nextState = cachePkg::IDLE;
        else if (missDirty) nextState = cachePkg::WRITEBACK;
        else nextState = cachePkg::REFILL;
      end
      cachePkg::WRITEBACK: if (lastBeat) nextState = cachePkg::REFILL;
      cachePkg::REFILL:    if (lastBeat) nextState = cachePkg::LOOKUP;
      cachePkg::FLUSHSCAN: begin
        if (scanDirty) nextState = cachePkg::FLUSHWB;
        else if (flushLast) nextState = cachePkg::IDLE;
      end
      cachePkg::FLUSHWB:   if (lastBeat) nextState = cachePkg::FLUSHSCAN;
      default:             nextState = cachePkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= cachePkg::IDLE;
      beat      <= '0;
      flushSet  <= '0;
      flushWay  <= 1'b0;
      victimWay <= 1'b0;
    end else begin
      state <= nextState;
      // Bursts are always four beats, so the counter wraps on its own
      if (memFire) beat <= beat + 1'b1;
      if (flushFire) begin
        {flushSet, flushWay} <= '0;
      end else if (state == cachePkg::FLUSHSCAN && !scanDirty) begin
        {flushSet, flushWay} <= flushNext;
      end
      if (state == cachePkg::LOOKUP && !hit) victimWay <= missWay;
    end
  end

  always_ff @(posedge clk) begin
    if (cpuFire) begin
      reqAddr  <= cpuAddr;
      reqWrite <= cpuWrite;
      reqWData <= cpuWData;
      reqMask  <= cpuByteMask;
    end
    if (state == cachePkg::LOOKUP && !hit) victimTag <= missTag;
  end

  assign cpuReady     = (state == cachePkg::IDLE) & ~flushValid;
  assign flushReady   = (state == cachePkg::IDLE);
  assign cpuRespValid = (state == cachePkg::LOOKUP) & hit;
  assign flushDone    = (state == cachePkg::FLUSHSCAN) & ~scanDirty & flushLast;
  assign memValid     = (state == cachePkg::WRITEBACK) | (state == cachePkg::REFILL) |
                        (state == cachePkg::FLUSHWB);
  assign memWrite     = (state == cachePkg::WRITEBACK) | (state == cachePkg::FLUSHWB);
  assign memWData     = dataRData;

  always_comb begin
    memAddr          = {reqTag, reqSet, refillOff, 2'b00};
    status.lookupSet = reqSet;
    status.updEn     = 1'b0;
    status.updWay    = victimWay;
    status.updTag    = reqTag;
    status.updValid  = 1'b1;
    status.updDirty  = 1'b0;
    status.touchEn   = 1'b0;
    status.touchWay  = hitWay;
    dataSet          = reqSet;
    dataWay          = victimWay;
    // Writeback reads one word ahead of the beat being sent
    dataWordOff      = memFire ? beat + 2'd1 : beat;
    dataWe           = 1'b0;
    dataByteMask     = '1;
    dataWData        = memRData;
    case (state)
      cachePkg::IDLE: begin
        status.lookupSet = flushValid ? '0 : cpuSet;
        dataSet          = cpuSet;
        dataWordOff      = cpuOff;
      end
      cachePkg::LOOKUP: begin
        dataWay     = hit ? hitWay : missWay;
        dataWordOff = hit ? reqOff : '0;
        if (hit) begin
          status.touchEn = 1'b1;
          if (reqWrite) begin
            dataWe          = 1'b1;
            dataByteMask    = reqMask;
            dataWData       = reqWData;
            status.updEn    = 1'b1;
            status.updWay   = hitWay;
            status.updDirty = 1'b1;
          end
        end
      end
      cachePkg::WRITEBACK: memAddr = {victimTag, reqSet, beat, 2'b00};
      cachePkg::REFILL: begin
        dataWordOff  = refillOff;
        dataWe       = memFire;
        status.updEn = lastBeat;
      end
      cachePkg::FLUSHSCAN: begin
        status.lookupSet = scanDirty ? flushSet : flushNext[`SET_W:1];
        dataSet          = flushSet;
        dataWay          = flushWay;
        dataWordOff      = '0;
        // Clean or empty line, just invalidate
        status.updEn     = ~scanDirty;
        status.updWay    = flushWay;
        status.updTag    = scanTag;
        status.updValid  = 1'b0;
      end
      cachePkg::FLUSHWB: begin
        memAddr          = {scanTag, flushSet, beat, 2'b00};
        status.lookupSet = flushSet;
        dataSet          = flushSet;
        dataWay          = flushWay;
        status.updEn     = lastBeat;
        status.updWay    = flushWay;
        status.updTag    = scanTag;
        status.updValid  = 1'b0;
      end
      default: ;
    endcase
  end

endmodule

//--- logic/dataCache.sv
`timescale 1ns/1ps

module dataCache (
  input  logic               clk,
  input  logic               reset,
  input  logic               cpuValid,
  output logic               cpuReady,
  input  logic               cpuWrite,
  input  cachePkg::addrT     cpuAddr,
  input  cachePkg::wordT     cpuWData,
  input  cachePkg::byteMaskT cpuByteMask,
  output logic               cpuRespValid,
  output cachePkg::wordT     cpuRData,
  input  logic               flushValid,
  output logic               flushReady,
  output logic               flushDone,
  output logic               memValid,
  input  logic               memReady,
  output logic               memWrite,
  output cachePkg::addrT     memAddr,
  output cachePkg::wordT     memWData,
  input  cachePkg::wordT     memRData
);

  cachePkg::setT      dataSet;
  logic               dataWay;
  cachePkg::wordOffT  dataWordOff;
  logic               dataWe;
  cachePkg::byteMaskT dataByteMask;
  cachePkg::wordT     dataWData;
  cachePkg::wordT     dataRData;

  wayStatusIf statusBus ();

  tagStore u_tagStore (
    .clk    (clk),
    .reset  (reset),
    .status (statusBus.store)
  );

  dataStore u_dataStore (
    .clk      (clk),
    .set      (dataSet),
    .way      (dataWay),
    .wordOff  (dataWordOff),
    .we       (dataWe),
    .byteMask (dataByteMask),
    .wData    (dataWData),
    .rData    (dataRData)
  );

  cacheController u_cacheController (
    .clk          (clk),
    .reset        (reset),
    .cpuValid     (cpuValid),
    .cpuReady     (cpuReady),
    .cpuWrite     (cpuWrite),
    .cpuAddr      (cpuAddr),
    .cpuWData     (cpuWData),
    .cpuByteMask  (cpuByteMask),
    .cpuRespValid (cpuRespValid),
    .flushValid   (flushValid),
    .flushReady   (flushReady),
    .flushDone    (flushDone),
    .memValid     (memValid),
    .memReady     (memReady),
    .memWrite     (memWrite),
    .memAddr      (memAddr),
    .memWData     (memWData),
    .memRData     (memRData),
    .status       (statusBus.ctrl),
    .dataSet      (dataSet),
    .dataWay      (dataWay),
    .dataWordOff  (dataWordOff),
    .dataWe       (dataWe),
    .dataByteMask (dataByteMask),
    .dataWData    (dataWData),
    .dataRData    (dataRData)
  );

  // Read hits come straight from the data array
  assign cpuRData = dataRData;

endmodule

//--- dv/dataCache_sva.sv
`timescale 1ns/1ps

module dataCacheSva (
  input logic           clk,
  input logic           reset,
  input logic           memValid,
  input logic           memReady,
  input logic           memWrite,
  input cachePkg::addrT memAddr,
  input cachePkg::wordT memWData
);

  int failCount = 0;

  // Stalled memory request holds its fields
  memHeld: assert property (@(posedge clk) disable iff (reset)
    memValid && !memReady |=> memValid && $stable(memWrite) && $stable(memAddr))
    else begin
      failCount++;
      $error("memory request changed while memReady was low");
    end

  memDataHeld: assert property (@(posedge clk) disable iff (reset)
    memValid && memWrite && !memReady |=> $stable(memWData))
    else begin
      failCount++;
      $error("memory write data changed while memReady was low");
    end

  // Writeback beats of one line go out at consecutive word offsets
  burstStep: assert property (@(posedge clk) disable iff (reset)
    memValid && memWrite && memReady && memAddr[3:2] != 2'd3 |=>
      memValid && memWrite && $stable(memAddr[31:4]) &&
      memAddr[3:2] == $past(memAddr[3:2]) + 2'd1)
    else begin
      failCount++;
      $error("writeback beat did not follow the previous one");
    end

endmodule

bind dataCache dataCacheSva u_dataCacheSva (.*);

//--- dv/cacheChecker.sv
`timescale 1ns/1ps

module cacheChecker (
  input  logic               clk,
  input  logic               reset,
  input  logic               cpuValid,
  input  logic               cpuReady,
  input  logic               cpuWrite,
  input  cachePkg::addrT     cpuAddr,
  input  cachePkg::wordT     cpuWData,
  input  cachePkg::byteMaskT cpuByteMask,
  input  logic               cpuRespValid,
  input  cachePkg::wordT     cpuRData,
  input  logic               flushValid,
  input  logic               flushReady,
  input  logic               flushDone,
  input  logic               memValid,
  input  logic               memReady,
  input  logic               memWrite,
  input  cachePkg::addrT     memAddr,
  input  cachePkg::wordT     memWData,
  input  cachePkg::wordT     memRData,
  input  int                 testId,
  input  logic               testEnd,
  input  logic               expectWb,
  output int                 errCount,
  output int                 checkCount
);

  // Reference view of memory as the CPU sees it, and the backing copy
  cachePkg::wordT refMem [cachePkg::addrT];
  cachePkg::wordT shadowMem [cachePkg::addrT];
  bit             written [cachePkg::addrT];

  cachePkg::addrT     reqAddr;
  logic               reqWrite;
  cachePkg::wordT     reqWData;
  cachePkg::byteMaskT reqMask;
  cachePkg::addrT     wordAddr;
  logic [27:0]        lastRespLine;
  int cycle = 0;
  int lastRespCycle = -10;
  int hitDue = -1;
  int wrCount = 0;
  int rdCount = 0;
  int wbBeats = 0;
  int testErrStart = 0;
  logic missDue = 1'b0;
  logic busy = 1'b0;

  initial begin
    errCount   = 0;
    checkCount = 0;
  end

  function automatic string testName(int id);
    case (id)
      0: return "reset";
      1: return "hit latency";
      2: return "random with back-pressure";
      3: return "eviction";
      4: return "flush";
      default: return "unknown";
    endcase
  endfunction

  function automatic cachePkg::wordT applyMask(cachePkg::wordT base, cachePkg::wordT d,
                                               cachePkg::byteMaskT m);
    cachePkg::wordT r;
    r = base;
    for (int b = 0; b < 4; b++) begin
      if (m[b]) r[b*8 +: 8] = d[b*8 +: 8];
    end
    return r;
  endfunction

  task automatic reportValue(string what, cachePkg::wordT exp, cachePkg::wordT act);
    errCount++;
    $display("Fail %s: %s expected %h actual %h", testName(testId), what, exp, act);
  endtask

  task automatic reportText(string msg);
    errCount++;
    $display("Error in %s: %s", testName(testId), msg);
  endtask

  always @(negedge clk) begin
    cycle++;
    if (testId == 0) begin
      checkCount++;
      if (memValid || cpuRespValid || flushDone) reportText("output active before any request");
    end
    if (!reset) begin
      // Neither port takes work from acceptance until the response or flushDone
      if (busy) begin
        checkCount++;
        if (cpuReady || flushReady) reportText("ready high while a request was in progress");
      end
      if (flushValid && cpuReady) reportText("cpuReady high while a flush was pending");
      if (flushValid && flushReady) busy = 1'b1;
      if (cpuValid && cpuReady) begin
        busy = 1'b1;
        // Same line right after its response must hit
        if (cycle == lastRespCycle + 1 && cpuAddr[31:4] == lastRespLine) hitDue = cycle + 1;
        reqAddr  = cpuAddr;
        reqWrite = cpuWrite;
        reqWData = cpuWData;
        reqMask  = cpuByteMask;
        wrCount  = 0;
        rdCount  = 0;
      end
      if (hitDue == cycle) begin
        checkCount++;
        if (!cpuRespValid) reportText("hit response did not come one cycle after acceptance");
      end
      if (memValid && memReady) begin
        checkCount++;
        if (memWrite) begin
          if (memAddr[3:2] != wbBeats[1:0]) reportText("writeback beats out of order");
          if (!refMem.exists(memAddr)) reportText("writeback of a word never loaded");
          else if (memWData != refMem[memAddr]) reportValue("writeback data", refMem[memAddr],
                                                            memWData);
          shadowMem[memAddr] = memWData;
          wbBeats++;
          wrCount++;
        end else begin
          if (wbBeats % 4 != 0) reportText("memory read inside an unfinished writeback");
          if (!refMem.exists(memAddr)) refMem[memAddr] = memRData;
          else if (memRData != refMem[memAddr]) reportValue("refill data", refMem[memAddr],
                                                            memRData);
          rdCount++;
        end
      end
      if (cpuRespValid) begin
        busy     = 1'b0;
        wordAddr = {reqAddr[31:2], 2'b00};
        if (!refMem.exists(wordAddr)) begin
          reportText("response for a word never loaded from memory");
        end else if (reqWrite) begin
          refMem[wordAddr]  = applyMask(refMem[wordAddr], reqWData, reqMask);
          written[wordAddr] = 1'b1;
        end else begin
          checkCount++;
          if (cpuRData != refMem[wordAddr]) reportValue("read data", refMem[wordAddr], cpuRData);
        end
        if (missDue) begin
          checkCount++;
          if (rdCount == 0) reportText("first access after flush did not miss");
          missDue = 1'b0;
        end
        if (expectWb) begin
          checkCount++;
          if (wrCount != 4) reportValue("writeback beat count", 4, wrCount);
        end
        lastRespCycle = cycle;
        lastRespLine  = reqAddr[31:4];
      end
      if (flushDone) begin
        busy = 1'b0;
        foreach (written[a]) begin
          checkCount++;
          if (!shadowMem.exists(a)) reportText("written word never reached memory");
          else if (shadowMem[a] != refMem[a]) reportValue("flushed word", refMem[a], shadowMem[a]);
        end
        missDue = 1'b1;
      end
      if (testEnd) begin
        $display("Test %s: %0d errors", testName(testId), errCount - testErrStart);
        testErrStart = errCount;
      end
    end
  end

endmodule

//--- dv/dataCacheTb.sv
`timescale 1ns/1ps

module dataCacheTb;

  localparam int NUM_RANDOM   = 200;
  // Worst case per request is a writeback plus a refill under back-pressure
  localparam int REQ_CYCLES   = 80;
  localparam int FLUSH_CYCLES = 32 * 40;
  localparam int CYCLE_LIMIT  = 100 + (NUM_RANDOM + 10) * REQ_CYCLES + FLUSH_CYCLES;

  logic               clk;
  logic               reset;
  logic               cpuValid;
  logic               cpuReady;
  logic               cpuWrite;
  cachePkg::addrT     cpuAddr;
  cachePkg::wordT     cpuWData;
  cachePkg::byteMaskT cpuByteMask;
  logic               cpuRespValid;
  cachePkg::wordT     cpuRData;
  logic               flushValid;
  logic               flushReady;
  logic               flushDone;
  logic               memValid;
  logic               memReady;
  logic               memWrite;
  cachePkg::addrT     memAddr;
  cachePkg::wordT     memWData;
  cachePkg::wordT     memRData;

  int   testId;
  logic testEnd;
  logic expectWb;
  int   errCount;
  int   checkCount;
  int   assertFails;
  int   cycles;

  logic [31:0]    lfsr;
  cachePkg::wordT memArr [cachePkg::addrT];
  cachePkg::tagT  tagPool [3];
  cachePkg::setT  setPool [2];

  dataCache u_dataCache (.*);

  cacheChecker u_checker (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] randBits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Unwritten memory holds a pattern of the full address
  function automatic cachePkg::wordT readMem(cachePkg::addrT a);
    if (memArr.exists(a)) return memArr[a];
    return a ^ {a[15:0], a[31:16]} ^ 32'h5A3C_96E1;
  endfunction

  function automatic cachePkg::addrT makeAddr(cachePkg::tagT t, cachePkg::setT s,
                                              cachePkg::wordOffT o);
    return {t, s, o, 2'b00};
  endfunction

  // Memory responder
  always @(posedge clk) begin
    #1;
    memReady = 1'(randBits(1));
    memRData = readMem(memAddr);
  end

  always @(negedge clk) begin
    if (!reset && memValid && memReady && memWrite) memArr[memAddr] = memWData;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $finish;
    end
  end

  // Called at a rising edge, returns at the edge after the response
  task automatic doRequest(input logic wr, input cachePkg::addrT a,
                           input cachePkg::wordT d, input cachePkg::byteMaskT m);
    #1;
    cpuValid    = 1'b1;
    cpuWrite    = wr;
    cpuAddr     = a;
    cpuWData    = d;
    cpuByteMask = m;
    do @(negedge clk); while (!cpuReady);
    @(posedge clk);
    #1;
    cpuValid = 1'b0;
    do @(negedge clk); while (!cpuRespValid);
    @(posedge clk);
  endtask

  task automatic doFlush();
    #1;
    flushValid = 1'b1;
    do @(negedge clk); while (!flushReady);
    @(posedge clk);
    #1;
    flushValid = 1'b0;
    do @(negedge clk); while (!flushDone);
    @(posedge clk);
  endtask

  task automatic endTest();
    #1;
    testEnd = 1'b1;
    @(posedge clk);
    #1;
    testEnd = 1'b0;
    testId++;
    @(posedge clk);
  endtask

  task automatic runRandom();
    cachePkg::addrT     a;
    cachePkg::wordT     d;
    cachePkg::byteMaskT m;
    logic               wr;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      a  = makeAddr(tagPool[2'(randBits(2) % 3)], setPool[1'(randBits(1))],
                    2'(randBits(2)));
      wr = 1'(randBits(1));
      m  = 4'(randBits(4));
      d  = randBits(32);
      doRequest(wr, a, d, m);
    end
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    cpuValid    = 1'b0;
    cpuWrite    = 1'b0;
    cpuAddr     = '0;
    cpuWData    = '0;
    cpuByteMask = '0;
    flushValid  = 1'b0;
    memReady    = 1'b0;
    memRData    = '0;
    testId      = 0;
    testEnd     = 1'b0;
    expectWb    = 1'b0;
    cycles      = 0;
    assertFails = 0;
    lfsr        = 32'd34;
    tagPool     = '{24'h000010, 24'h0ABC01, 24'h123456};
    setPool     = '{4'd3, 4'd9};

    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (6) @(posedge clk);
    endTest();

    // Back-to-back requests to one line
    doRequest(1'b1, makeAddr(24'h000077, 4'd5, 2'd0), 32'hCAFE_0001, 4'hF);
    doRequest(1'b0, makeAddr(24'h000077, 4'd5, 2'd0), '0, 4'hF);
    doRequest(1'b0, makeAddr(24'h000077, 4'd5, 2'd1), '0, 4'hF);
    doRequest(1'b1, makeAddr(24'h000077, 4'd5, 2'd2), 32'h1234_5678, 4'h6);
    doRequest(1'b0, makeAddr(24'h000077, 4'd5, 2'd2), '0, 4'hF);
    endTest();

    runRandom();
    endTest();

    // Two dirty ways in set 12, then a third tag
    doRequest(1'b1, makeAddr(24'h0E0000, 4'd12, 2'd1), 32'hAAAA_5555, 4'hF);
    doRequest(1'b1, makeAddr(24'h0E0001, 4'd12, 2'd2), 32'h0F0F_F0F0, 4'h3);
    expectWb = 1'b1;
    doRequest(1'b0, makeAddr(24'h0E0002, 4'd12, 2'd3), '0, 4'hF);
    expectWb = 1'b0;
    doRequest(1'b0, makeAddr(24'h0E0000, 4'd12, 2'd1), '0, 4'hF);
    endTest();

    doFlush();
    doRequest(1'b0, makeAddr(24'h0E0001, 4'd12, 2'd2), '0, 4'hF);
    endTest();

    assertFails = u_dataCache.u_dataCacheSva.failCount;
    $display("Tests run: %0d, checks: %0d, errors: %0d", testId, checkCount,
             errCount + assertFails);
    if (errCount + assertFails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+logic
logic/cachePkg.sv
logic/wayStatusIf.sv
logic/tagStore.sv
logic/dataStore.sv
logic/cacheController.sv
logic/dataCache.sv
dv/dataCache_sva.sv
dv/cacheChecker.sv
dv/dataCacheTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dataCacheTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
